//--- sources.f
+incdir+verilog
verilog/ising_pkg.sv
verilog/analog_cfg_if.sv
verilog/synchronizer.sv
verilog/analog_tx.sv
verilog/analog_rx.sv
verilog/analog_cfg_regs.sv
verilog/analog_io_top.sv
test/analog_io_assertions.sv
test/tb_analog_io.sv

//--- test/tb_analog_io.sv
// testbench for analog_io_top with a behavioural model of the analog Ising macro
// the macro answers each start with the inverted spins after 3 to 20 cycles
// latency and stream rules are checked by the bound assertion module
// inputs change on the falling clock edge; outputs are read there, AXI ready at the rising edge
`default_nettype none
`include "ising_params.svh"

module tb_analog_io;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 200;
    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic                       clk;
    logic                       rst_n;
    logic [31:0]                s_axi_awaddr;
    logic                       s_axi_awvalid;
    logic                       s_axi_awready;
    logic [31:0]                s_axi_wdata;
    logic [3:0]                 s_axi_wstrb;
    logic                       s_axi_wvalid;
    logic                       s_axi_wready;
    logic [1:0]                 s_axi_bresp;
    logic                       s_axi_bvalid;
    logic                       s_axi_bready;
    logic [31:0]                s_axi_araddr;
    logic                       s_axi_arvalid;
    logic                       s_axi_arready;
    logic [31:0]                s_axi_rdata;
    logic [1:0]                 s_axi_rresp;
    logic                       s_axi_rvalid;
    logic                       s_axi_rready;
    logic                       in_valid;
    logic                       in_ready;
    logic [`ISING_NUM_SPIN-1:0] in_spin;
    logic                       out_valid;
    logic                       out_ready;
    logic [`ISING_NUM_SPIN-1:0] out_spin;
    logic [`ISING_NUM_SPIN-1:0] macro_spin_o;
    logic                       macro_start;
    logic [`ISING_NUM_SPIN-1:0] macro_spin_i;
    logic                       macro_finish;

    logic [`ISING_NUM_SPIN-1:0] vecs [16];
    int                         seed;
    int                         err_cnt;
    int                         test_err_base;
    int                         tests_run;
    int                         tests_failed;
    int                         hs_cnt;
    int                         cur_depth;

    analog_io_top u_dut (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .s_axi_awaddr_i  (s_axi_awaddr),
        .s_axi_awvalid_i (s_axi_awvalid),
        .s_axi_awready_o (s_axi_awready),
        .s_axi_wdata_i   (s_axi_wdata),
        .s_axi_wstrb_i   (s_axi_wstrb),
        .s_axi_wvalid_i  (s_axi_wvalid),
        .s_axi_wready_o  (s_axi_wready),
        .s_axi_bresp_o   (s_axi_bresp),
        .s_axi_bvalid_o  (s_axi_bvalid),
        .s_axi_bready_i  (s_axi_bready),
        .s_axi_araddr_i  (s_axi_araddr),
        .s_axi_arvalid_i (s_axi_arvalid),
        .s_axi_arready_o (s_axi_arready),
        .s_axi_rdata_o   (s_axi_rdata),
        .s_axi_rresp_o   (s_axi_rresp),
        .s_axi_rvalid_o  (s_axi_rvalid),
        .s_axi_rready_i  (s_axi_rready),
        .in_valid_i      (in_valid),
        .in_ready_o      (in_ready),
        .in_spin_i       (in_spin),
        .out_valid_o     (out_valid),
        .out_ready_i     (out_ready),
        .out_spin_o      (out_spin),
        .macro_spin_o    (macro_spin_o),
        .macro_start_o   (macro_start),
        .macro_spin_i    (macro_spin_i),
        .macro_finish_i  (macro_finish)
    );

    bind analog_io_top analog_io_assertions u_asrt (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .en_i           (u_cfg.en),
        .depth_i        (u_cfg.depth_q),
        .rx_busy_i      (u_cfg.rx_busy),
        .in_valid_i     (in_valid_i),
        .in_ready_i     (in_ready_o),
        .out_valid_i    (out_valid_o),
        .out_ready_i    (out_ready_i),
        .macro_start_i  (macro_start_o),
        .macro_finish_i (macro_finish_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // analog macro, one run at a time
    initial begin : macro_model
        logic [`ISING_NUM_SPIN-1:0] held;
        int                         lat;
        macro_spin_i = '0;
        macro_finish = 1'b0;
        forever begin
            @(negedge clk);
            if (macro_start) begin
                held = macro_spin_o;
                lat  = 3 + ($unsigned($random(seed)) % 18);
                repeat (lat) @(negedge clk);
                macro_spin_i = ~held;
                macro_finish = 1'b1;
                @(negedge clk);
                macro_finish = 1'b0;
            end
        end
    end

    function automatic int total_errors();
        return err_cnt + u_dut.u_asrt.fail_cnt;
    endfunction

    task automatic check_value(input string what, input logic [`ISING_NUM_SPIN-1:0] got,
                               input logic [`ISING_NUM_SPIN-1:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp, input string what);
        int   t;
        logic accepted;
        @(negedge clk);
        s_axi_awaddr  = addr;
        s_axi_awvalid = 1'b1;
        s_axi_wdata   = data;
        s_axi_wstrb   = 4'hf;
        s_axi_wvalid  = 1'b1;
        t = 0;
        // AW and W are taken on the rising edge where both readies are high
        do begin
            @(posedge clk);
            t++;
        end while (!(s_axi_awready && s_axi_wready) && t < WAIT_LIMIT);
        accepted = s_axi_awready && s_axi_wready;
        @(negedge clk);
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        if (!accepted) begin
            err_cnt++;
            $display("write to %s was not accepted within %0d cycles", what, WAIT_LIMIT);
        end else begin
            t = 0;
            while (!s_axi_bvalid && t < WAIT_LIMIT) begin
                @(negedge clk);
                t++;
            end
            if (!s_axi_bvalid) begin
                err_cnt++;
                $display("write to %s got no response within %0d cycles", what, WAIT_LIMIT);
            end else if (s_axi_bresp !== exp_resp) begin
                err_cnt++;
                $display("Mismatch at %0d ns: write %s response %b, expected %b",
                         $time, what, s_axi_bresp, exp_resp);
            end
        end
    endtask

    task automatic read_reg(input logic [31:0] addr, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp, input string what);
        int   t;
        logic accepted;
        @(negedge clk);
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!s_axi_arready && t < WAIT_LIMIT);
        accepted = s_axi_arready;
        @(negedge clk);
        s_axi_arvalid = 1'b0;
        if (!accepted) begin
            err_cnt++;
            $display("read of %s was not accepted within %0d cycles", what, WAIT_LIMIT);
        end else begin
            t = 0;
            while (!s_axi_rvalid && t < WAIT_LIMIT) begin
                @(negedge clk);
                t++;
            end
            if (!s_axi_rvalid) begin
                err_cnt++;
                $display("read of %s got no response within %0d cycles", what, WAIT_LIMIT);
            end else begin
                if (s_axi_rresp !== exp_resp) begin
                    err_cnt++;
                    $display("Mismatch at %0d ns: read %s response %b, expected %b",
                             $time, what, s_axi_rresp, exp_resp);
                end
                if (s_axi_rdata !== exp_data) begin
                    err_cnt++;
                    $display("Mismatch at %0d ns: read %s data %h, expected %h",
                             $time, what, s_axi_rdata, exp_data);
                end
            end
        end
    endtask

    // in_ready only changes on a rising edge, so it is stable here
    task automatic send_vector(input logic [`ISING_NUM_SPIN-1:0] spin);
        int t;
        t = 0;
        @(negedge clk);
        while (!in_ready && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!in_ready) begin
            err_cnt++;
            $display("input stream never became ready within %0d cycles", WAIT_LIMIT);
        end else begin
            in_spin  = spin;
            in_valid = 1'b1;
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic poll_out_valid();
        int t;
        t = 0;
        while (!out_valid && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!out_valid) begin
            err_cnt++;
            $display("output stream never became valid within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic wait_rx_idle();
        int t;
        t = 0;
        while (!in_ready && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!in_ready) begin
            err_cnt++;
            $display("rx path stayed busy for %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic take_result(input logic [`ISING_NUM_SPIN-1:0] expected);
        poll_out_valid();
        if (out_valid) begin
            check_value("out_spin_o", out_spin, expected);
            out_ready = 1'b1;
            @(negedge clk);
            out_ready = 1'b0;
            hs_cnt++;
        end
    endtask

    task automatic start_test();
        test_err_base = total_errors();
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = total_errors() - test_err_base;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d error(s)", name, errs);
        end
    endtask

    initial begin : stimulus
        seed          = 32'hb4aa_9424;
        err_cnt       = 0;
        tests_run     = 0;
        tests_failed  = 0;
        hs_cnt        = 0;
        cur_depth     = 3;
        rst_n         = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b1;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b1;
        in_valid      = 1'b0;
        in_spin       = '0;
        out_ready     = 1'b0;
        for (int i = 0; i < 16; i++) begin
            vecs[i] = {$random(seed), $random(seed)};
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start_test();
        read_reg(`ISING_REG_STATUS, 32'h1, RESP_OKAY, "STATUS");
        read_reg(`ISING_REG_DEPTH, 32'h3, RESP_OKAY, "DEPTH");
        check_value("out_valid_o", out_valid, 0);
        check_value("in_ready_o", in_ready, 0);
        check_value("macro_start_o", macro_start, 0);
        end_test("1 reset state");

        start_test();
        write_reg(`ISING_REG_CTRL, 32'h1, RESP_OKAY, "CTRL");
        read_reg(`ISING_REG_CTRL, 32'h1, RESP_OKAY, "CTRL");
        for (int i = 0; i < 4; i++) begin
            send_vector(vecs[i]);
            take_result(~vecs[i]);
        end
        end_test("2 inverted spins");

        start_test();
        for (int d = 0; d < `ISING_SYNC_DEPTH; d++) begin
            write_reg(`ISING_REG_DEPTH, 32'(d), RESP_OKAY, "DEPTH");
            read_reg(`ISING_REG_DEPTH, 32'(d), RESP_OKAY, "DEPTH");
            cur_depth = d;
            send_vector(vecs[4 + d]);
            take_result(~vecs[4 + d]);
        end
        end_test("3 depth sweep");

        // two runs finish while the output is not taken
        start_test();
        send_vector(vecs[8]);
        poll_out_valid();
        send_vector(vecs[9]);
        wait_rx_idle();
        repeat (cur_depth + 3) @(negedge clk);
        check_value("out_valid_o", out_valid, 1);
        take_result(~vecs[9]);
        end_test("4 back-pressure");

        start_test();
        read_reg(`ISING_REG_COUNT, 32'(hs_cnt), RESP_OKAY, "COUNT");
        send_vector(vecs[10]);
        poll_out_valid();
        write_reg(`ISING_REG_CTRL, 32'h0, RESP_OKAY, "CTRL");
        read_reg(`ISING_REG_COUNT, 32'h0, RESP_OKAY, "COUNT");
        check_value("in_ready_o", in_ready, 0);
        check_value("out_valid_o", out_valid, 0);
        end_test("5 result count and disable");

        start_test();
        write_reg(`ISING_REG_STATUS, 32'h3, RESP_SLVERR, "STATUS");
        write_reg(32'h0000_0010, 32'h1, RESP_SLVERR, "address 0x10");
        read_reg(32'h0000_0020, 32'h0, RESP_SLVERR, "address 0x20");
        read_reg(`ISING_REG_CTRL, 32'h0, RESP_OKAY, "CTRL");
        read_reg(`ISING_REG_DEPTH, 32'(cur_depth), RESP_OKAY, "DEPTH");
        read_reg(`ISING_REG_STATUS, 32'h1, RESP_OKAY, "STATUS");
        read_reg(`ISING_REG_COUNT, 32'h0, RESP_OKAY, "COUNT");
        end_test("6 error responses");

        $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, err_cnt, u_dut.u_asrt.fail_cnt);
        if (total_errors() == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/analog_io_assertions.sv
// protocol and latency checks for analog_io_top, attached with bind
// the latency check assumes depth is not rewritten and no other capture is in flight
// fail_cnt counts every failed check
`default_nettype none
`include "ising_params.svh"

module analog_io_assertions (
    input logic                         clk_i,
    input logic                         rst_n_i,
    input logic                         en_i,
    input logic [`ISING_SYNC_SEL_W-1:0] depth_i,
    input logic                         rx_busy_i,
    input logic                         in_valid_i,
    input logic                         in_ready_i,
    input logic                         out_valid_i,
    input logic                         out_ready_i,
    input logic                         macro_start_i,
    input logic                         macro_finish_i
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;

    // out_valid rises exactly depth+2 cycles after finish, one property per depth value
    for (genvar d = 0; d < `ISING_SYNC_DEPTH; d++) begin : g_lat
        a_finish_to_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            (macro_finish_i && en_i && depth_i == d && !out_valid_i)
                |-> !out_valid_i [*(d + 2)] ##1 out_valid_i)
        else begin
            fail_cnt++;
            $error("out_valid_o did not rise %0d cycles after macro_finish_i", d + 2);
        end
    end

    // held result must survive until it is taken
    a_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (out_valid_i && !out_ready_i && en_i) |=> out_valid_i)
    else begin
        fail_cnt++;
        $error("out_valid_o dropped without a handshake");
    end

    a_start_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        macro_start_i |=> !macro_start_i)
    else begin
        fail_cnt++;
        $error("macro_start_o high for more than one cycle");
    end

    // start only follows a transfer accepted while idle
    a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        macro_start_i |-> $past(in_valid_i && in_ready_i && !rx_busy_i))
    else begin
        fail_cnt++;
        $error("macro_start_o without a transfer into an idle rx path");
    end

endmodule

`default_nettype wire

//--- verilog/analog_io_top.sv
// digital side of the analog Ising macro boundary
// finish-to-out_valid latency is depth+2 cycles; the macro latency itself is free
// the path stays dead until CTRL.en is written high
`default_nettype none
`include "ising_params.svh"

module analog_io_top (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic [31:0]                s_axi_awaddr_i,
    input  logic                       s_axi_awvalid_i,
    output logic                       s_axi_awready_o,
    input  logic [31:0]                s_axi_wdata_i,
    input  logic [3:0]                 s_axi_wstrb_i,
    input  logic                       s_axi_wvalid_i,
    output logic                       s_axi_wready_o,
    output logic [1:0]                 s_axi_bresp_o,
    output logic                       s_axi_bvalid_o,
    input  logic                       s_axi_bready_i,
    input  logic [31:0]                s_axi_araddr_i,
    input  logic                       s_axi_arvalid_i,
    output logic                       s_axi_arready_o,
    output logic [31:0]                s_axi_rdata_o,
    output logic [1:0]                 s_axi_rresp_o,
    output logic                       s_axi_rvalid_o,
    input  logic                       s_axi_rready_i,
    input  logic                       in_valid_i,
    output logic                       in_ready_o,
    input  logic [`ISING_NUM_SPIN-1:0] in_spin_i,
    output logic                       out_valid_o,
    input  logic                       out_ready_i,
    output logic [`ISING_NUM_SPIN-1:0] out_spin_o,
    output logic [`ISING_NUM_SPIN-1:0] macro_spin_o,
    output logic                       macro_start_o,
    input  logic [`ISING_NUM_SPIN-1:0] macro_spin_i,
    input  logic                       macro_finish_i
);

    analog_cfg_if u_cfg ();

    analog_cfg_regs u_regs (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .s_axi_awaddr_i  (s_axi_awaddr_i),
        .s_axi_awvalid_i (s_axi_awvalid_i),
        .s_axi_awready_o (s_axi_awready_o),
        .s_axi_wdata_i   (s_axi_wdata_i),
        .s_axi_wstrb_i   (s_axi_wstrb_i),
        .s_axi_wvalid_i  (s_axi_wvalid_i),
        .s_axi_wready_o  (s_axi_wready_o),
        .s_axi_bresp_o   (s_axi_bresp_o),
        .s_axi_bvalid_o  (s_axi_bvalid_o),
        .s_axi_bready_i  (s_axi_bready_i),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_arready_o (s_axi_arready_o),
        .s_axi_rdata_o   (s_axi_rdata_o),
        .s_axi_rresp_o   (s_axi_rresp_o),
        .s_axi_rvalid_o  (s_axi_rvalid_o),
        .s_axi_rready_i  (s_axi_rready_i),
        .cfg             (u_cfg.regs)
    );

    analog_rx u_rx (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .cfg           (u_cfg.rx),
        .valid_i       (in_valid_i),
        .ready_o       (in_ready_o),
        .spin_i        (in_spin_i),
        .finish_i      (macro_finish_i),
        .macro_spin_o  (macro_spin_o),
        .macro_start_o (macro_start_o)
    );

    analog_tx u_tx (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .cfg      (u_cfg.tx),
        .spin_i   (macro_spin_i),
        .finish_i (macro_finish_i),
        .valid_o  (out_valid_o),
        .ready_i  (out_ready_i),
        .spin_o   (out_spin_o)
    );

endmodule

`default_nettype wire

//--- verilog/analog_cfg_regs.sv
// AXI4-Lite slave for control, depth, status and result count
// AW and W are taken together; B and R follow one cycle after acceptance
// only byte lane 0 is honoured on writes; STATUS and COUNT are read only
// writing CTRL with en low also clears COUNT
`default_nettype none
`include "ising_params.svh"

module analog_cfg_regs (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [31:0] s_axi_awaddr_i,
    input  logic        s_axi_awvalid_i,
    output logic        s_axi_awready_o,
    input  logic [31:0] s_axi_wdata_i,
    input  logic [3:0]  s_axi_wstrb_i,
    input  logic        s_axi_wvalid_i,
    output logic        s_axi_wready_o,
    output logic [1:0]  s_axi_bresp_o,
    output logic        s_axi_bvalid_o,
    input  logic        s_axi_bready_i,
    input  logic [31:0] s_axi_araddr_i,
    input  logic        s_axi_arvalid_i,
    output logic        s_axi_arready_o,
    output logic [31:0] s_axi_rdata_o,
    output logic [1:0]  s_axi_rresp_o,
    output logic        s_axi_rvalid_o,
    input  logic        s_axi_rready_i,
    analog_cfg_if.regs  cfg
);

    ising_pkg::reg_sel_e  wr_sel;
    ising_pkg::reg_sel_e  rd_sel;
    ising_pkg::axi_resp_e bresp_q;
    ising_pkg::axi_resp_e rresp_q;
    ising_pkg::status_t   status;
    logic                 wr_hit;
    logic                 rd_hit;
    logic                 wr_ok;
    logic                 wr_fire;
    logic                 rd_fire;
    logic                 ctrl_wr;
    logic                 bvalid_q;
    logic                 rvalid_q;
    logic                 en_q;
    logic [31:0]          count_q;
    logic [31:0]          rdata_q;
    logic [31:0]          rd_word;

    function automatic logic addr_hit(input logic [31:0] addr);
        return addr inside {`ISING_REG_CTRL, `ISING_REG_DEPTH,
                            `ISING_REG_STATUS, `ISING_REG_COUNT};
    endfunction

    assign wr_sel = ising_pkg::reg_sel_e'(s_axi_awaddr_i[3:2]);
    assign rd_sel = ising_pkg::reg_sel_e'(s_axi_araddr_i[3:2]);
    assign wr_hit = addr_hit(s_axi_awaddr_i);
    assign rd_hit = addr_hit(s_axi_araddr_i);

    // write channel, one outstanding response
    assign s_axi_awready_o = s_axi_wvalid_i & ~bvalid_q;
    assign s_axi_wready_o  = s_axi_awvalid_i & ~bvalid_q;
    assign wr_fire = s_axi_awvalid_i & s_axi_wvalid_i & ~bvalid_q;
    assign wr_ok   = wr_hit & (wr_sel == ising_pkg::REG_CTRL || wr_sel == ising_pkg::REG_DEPTH);
    assign ctrl_wr = wr_fire & wr_ok & s_axi_wstrb_i[0] & (wr_sel == ising_pkg::REG_CTRL);

    assign cfg.depth_wr  = wr_fire & wr_ok & s_axi_wstrb_i[0] & (wr_sel == ising_pkg::REG_DEPTH);
    assign cfg.depth_sel = s_axi_wdata_i[`ISING_SYNC_SEL_W-1:0];
    assign cfg.en        = en_q;

    // read channel
    assign s_axi_arready_o = ~rvalid_q;
    assign rd_fire = s_axi_arvalid_i & ~rvalid_q;

    assign status.rx_busy = cfg.rx_busy;
    assign status.tx_idle = cfg.tx_idle;

    always_comb begin
        rd_word = '0;
        if (rd_hit) begin
            case (rd_sel)
                ising_pkg::REG_CTRL:   rd_word[0] = en_q;
                ising_pkg::REG_DEPTH:  rd_word[`ISING_SYNC_SEL_W-1:0] = cfg.depth_q;
                ising_pkg::REG_STATUS: rd_word[1:0] = status;
                ising_pkg::REG_COUNT:  rd_word = count_q;
                default:               rd_word = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q     <= 1'b0;
            count_q  <= '0;
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                en_q <= s_axi_wdata_i[0];
            end
            if (ctrl_wr && !s_axi_wdata_i[0]) begin
                count_q <= '0;
            end else if (cfg.result_hs) begin
                count_q <= count_q + 32'd1;
            end
            if (wr_fire) begin
                bvalid_q <= 1'b1;
            end else if (s_axi_bready_i) begin
                bvalid_q <= 1'b0;
            end
            if (rd_fire) begin
                rvalid_q <= 1'b1;
            end else if (s_axi_rready_i) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // response payloads only matter while the matching valid is high
    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            bresp_q <= wr_ok ? ising_pkg::RESP_OKAY : ising_pkg::RESP_SLVERR;
        end
        if (rd_fire) begin
            rdata_q <= rd_word;
            rresp_q <= rd_hit ? ising_pkg::RESP_OKAY : ising_pkg::RESP_SLVERR;
        end
    end

    assign s_axi_bvalid_o = bvalid_q;
    assign s_axi_bresp_o  = bresp_q;
    assign s_axi_rvalid_o = rvalid_q;
    assign s_axi_rdata_o  = rdata_q;
    assign s_axi_rresp_o  = rresp_q;

endmodule

`default_nettype wire

//--- verilog/analog_rx.sv
// drives one spin vector per macro run and pulses start for one cycle
// accepts a new vector only when enabled and the previous run has finished
// a run that is started is always waited out, even if en drops meanwhile
`default_nettype none
`include "ising_params.svh"

module analog_rx (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    analog_cfg_if.rx                   cfg,
    input  logic                       valid_i,
    output logic                       ready_o,
    input  logic [`ISING_NUM_SPIN-1:0] spin_i,
    input  logic                       finish_i,
    output logic [`ISING_NUM_SPIN-1:0] macro_spin_o,
    output logic                       macro_start_o
);

    typedef enum logic {
        RX_IDLE,
        RX_BUSY
    } rx_state_e;

    rx_state_e                  state_q;
    logic                       start_q;
    logic [`ISING_NUM_SPIN-1:0] spin_q;
    logic                       take;

    assign ready_o = cfg.en & (state_q == RX_IDLE);
    assign take    = valid_i & ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= RX_IDLE;
            start_q <= 1'b0;
        end else begin
            // start follows the accepted vector by one cycle
            start_q <= take;
            case (state_q)
                RX_IDLE: if (take) state_q <= RX_BUSY;
                RX_BUSY: if (finish_i) state_q <= RX_IDLE;
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // held stable for the whole macro run
    always_ff @(posedge clk_i) begin
        if (take) begin
            spin_q <= spin_i;
        end
    end

    assign macro_spin_o  = spin_q;
    assign macro_start_o = start_q;
    assign cfg.rx_busy   = (state_q == RX_BUSY);

endmodule

`default_nettype wire

//--- verilog/analog_tx.sv
// turns macro finish events into a held valid/ready spin stream
// a newer capture overwrites an unaccepted result, older results are lost
// depth register resets to the maximum depth and loads only while enabled
`default_nettype none
`include "ising_params.svh"

module analog_tx (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    analog_cfg_if.tx                   cfg,
    input  logic [`ISING_NUM_SPIN-1:0] spin_i,
    input  logic                       finish_i,
    output logic                       valid_o,
    input  logic                       ready_i,
    output logic [`ISING_NUM_SPIN-1:0] spin_o
);

    logic [`ISING_SYNC_SEL_W-1:0] depth_q;
    logic                         sync_valid;
    logic [`ISING_NUM_SPIN-1:0]   sync_data;
    logic                         valid_q;
    logic [`ISING_NUM_SPIN-1:0]   spin_q;
    logic                         handshake;

    synchronizer u_sync (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (cfg.en),
        .trig_i  (finish_i),
        .sel_i   (depth_q),
        .data_i  (spin_i),
        .valid_o (sync_valid),
        .data_o  (sync_data)
    );

    assign handshake = valid_q & ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            depth_q <= '1;
            valid_q <= 1'b0;
        end else begin
            if (cfg.depth_wr && cfg.en) begin
                depth_q <= cfg.depth_sel;
            end
            // a fresh capture wins over handshake and disable
            if (sync_valid) begin
                valid_q <= 1'b1;
            end else if (handshake || !cfg.en) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sync_valid) begin
            spin_q <= sync_data;
        end
    end

    assign valid_o       = valid_q;
    assign spin_o        = spin_q;
    assign cfg.depth_q   = depth_q;
    assign cfg.tx_idle   = ~valid_q;
    assign cfg.result_hs = handshake;

endmodule

`default_nettype wire

//--- verilog/synchronizer.sv
// captures the macro outputs on a trigger pulse and walks them down a stage chain
// valid_o/data_o are tapped at stage sel_i, so valid comes sel_i+1 cycles after trigger
// changing sel_i while captures are in flight can skip or repeat one of them
// input data are forced to zero while en_i is low
`default_nettype none
`include "ising_params.svh"

module synchronizer (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         en_i,
    input  logic                         trig_i,
    input  logic [`ISING_SYNC_SEL_W-1:0] sel_i,
    input  logic [`ISING_NUM_SPIN-1:0]   data_i,
    output logic                         valid_o,
    output logic [`ISING_NUM_SPIN-1:0]   data_o
);

    logic [`ISING_SYNC_DEPTH-1:0] vld_q;
    logic [`ISING_NUM_SPIN-1:0]   data_q [`ISING_SYNC_DEPTH];
    logic [`ISING_NUM_SPIN-1:0]   data_gated;

    // enable gate in front of the first stage
    assign data_gated = en_i ? data_i : '0;

    // one valid bit per stage, several captures may be in flight
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[`ISING_SYNC_DEPTH-2:0], trig_i & en_i};
        end
    end

    // data follow their valid bit
    always_ff @(posedge clk_i) begin
        if (trig_i) begin
            data_q[0] <= data_gated;
        end
        for (int k = 1; k < `ISING_SYNC_DEPTH; k++) begin
            if (vld_q[k-1]) begin
                data_q[k] <= data_q[k-1];
            end
        end
    end

    assign valid_o = vld_q[sel_i];
    assign data_o  = data_q[sel_i];

endmodule

`default_nettype wire

//--- verilog/analog_cfg_if.sv
// configuration and status between the register block and the tx/rx paths
// depth_wr is a single-cycle strobe; depth_sel is only meaningful while it is high
`default_nettype none
`include "ising_params.svh"

interface analog_cfg_if;

    logic                         en;
    logic                         depth_wr;
    logic [`ISING_SYNC_SEL_W-1:0] depth_sel;
    logic [`ISING_SYNC_SEL_W-1:0] depth_q;
    logic                         tx_idle;
    logic                         rx_busy;
    logic                         result_hs;

    modport regs (
        output en, depth_wr, depth_sel,
        input  depth_q, tx_idle, rx_busy, result_hs
    );

    modport tx (
        input  en, depth_wr, depth_sel,
        output depth_q, tx_idle, result_hs
    );

    modport rx (
        input  en,
        output rx_busy
    );

endinterface

`default_nettype wire

//--- verilog/ising_pkg.sv
// types for the configuration block of the analog Ising boundary
// reg_sel_e follows address bits 3:2 of the register map
`default_nettype none

package ising_pkg;

    // register index taken from address bits 3:2
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_DEPTH  = 2'd1,
        REG_STATUS = 2'd2,
        REG_COUNT  = 2'd3
    } reg_sel_e;

    // only the two responses this slave can give
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    // bit 0 tx_idle, bit 1 rx_busy
    typedef struct packed {
        logic rx_busy;
        logic tx_idle;
    } status_t;

endpackage

`default_nettype wire

//--- verilog/ising_params.svh
// sizes and register map shared by the analog Ising boundary logic
// ISING_SYNC_DEPTH must equal 2**ISING_SYNC_SEL_W, the selector indexes every stage
// register addresses are byte addresses on a 32-bit AXI4-Lite bus
`ifndef ISING_PARAMS_SVH
`define ISING_PARAMS_SVH

`define ISING_NUM_SPIN   64
`define ISING_SYNC_DEPTH 4
`define ISING_SYNC_SEL_W 2

`define ISING_REG_CTRL   32'h0000_0000
`define ISING_REG_DEPTH  32'h0000_0004
`define ISING_REG_STATUS 32'h0000_0008
`define ISING_REG_COUNT  32'h0000_000C

`endif
